//--- include/esp_ctrl_cfg.svh
`ifndef ESP_CTRL_CFG_SVH
`define ESP_CTRL_CFG_SVH

// identification bytes returned to the ESP
`define ESP_CTRL_COOKIE        8'hAF
`define ESP_CTRL_VERSION_MAJOR 3'd0
`define ESP_CTRL_VERSION_MINOR 5'd3

// spi slave bit counter width, 8 bits per byte
`define ESP_CTRL_BIT_CNT_W     3

// parameter slots in the command parser
`define ESP_CTRL_MAX_PARAMS    2

// z80 reset pulse length in clocks
`define ESP_CTRL_RST_CYCLES    15

// flash sck half period in clocks
`define ESP_CTRL_FLASH_HALF_BIT 8

`define ESP_CTRL_KEYB_ROWS     8

`endif

//--- src/esp_ctrl_pkg.sv
`default_nettype none

package esp_ctrl_pkg;

  // opcodes from the ESP, first byte of every command
  typedef enum logic [7:0] {
    get_cookie       = 8'd0,
    get_version      = 8'd15,
    send_keyb        = 8'd19,
    ptrs_rst         = 8'd20,
    z80_pause        = 8'd21,
    z80_resume       = 8'd22,
    set_led          = 8'd26,
    set_spi_ctrl_reg = 8'd29,
    set_spi_data     = 8'd30,
    get_spi_data     = 8'd31,
    set_esp_status   = 8'd32
  } cmd_e;

  // command parser states
  // execute is never entered, it falls back to idle
  typedef enum logic [1:0] {
    idle       = 2'd0,
    read_bytes = 2'd1,
    execute    = 2'd2
  } parser_state_e;

endpackage

`default_nettype wire

//--- src/esp_spi_slave.sv
`timescale 1ns/100ps
`default_nettype none

`include "esp_ctrl_cfg.svh"

module esp_spi_slave (
  input  logic       clk,
  input  logic       cass_out_sel_n,
  input  logic       spi_cs_n,
  input  logic       spi_sck,
  input  logic       spi_mosi,
  input  logic [7:0] tx_byte,
  output logic       spi_miso,
  output logic [7:0] rx_byte,
  output logic       rx_valid
);

  logic [2:0] sck_sync;
  logic [1:0] cs_sync;
  logic [1:0] mosi_sync;
  logic       sck_rise;
  logic       sck_fall;
  logic       cs_active;

  logic [`ESP_CTRL_BIT_CNT_W-1:0] bit_cnt;
  logic [7:0] rx_shift;
  logic [7:0] tx_shift;

  // two sync stages and a third sck stage for edge detection
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      sck_sync  <= 3'b000;
      cs_sync   <= 2'b11;
      mosi_sync <= 2'b00;
    end else begin
      sck_sync  <= {sck_sync[1:0], spi_sck};
      cs_sync   <= {cs_sync[0], spi_cs_n};
      mosi_sync <= {mosi_sync[0], spi_mosi};
    end
  end

  assign sck_rise  = (sck_sync[2:1] == 2'b01);
  assign sck_fall  = (sck_sync[2:1] == 2'b10);
  assign cs_active = ~cs_sync[1];

  // bit counter and receive strobe
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (!cs_active) begin
        bit_cnt <= '0;
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + `ESP_CTRL_BIT_CNT_W'(1);
        if (&bit_cnt)
          rx_valid <= 1'b1;
      end
    end
  end

  // mosi in msb first
  always_ff @(posedge clk) begin
    if (cs_active && sck_rise)
      rx_shift <= {rx_shift[6:0], mosi_sync[1]};
  end

  assign rx_byte = rx_shift;

  // response loads at the first falling edge and puts bit 7 on the line
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      tx_shift <= 8'h00;
    end else if (cs_active && sck_fall) begin
      if (bit_cnt == `ESP_CTRL_BIT_CNT_W'(1))
        tx_shift <= tx_byte;
      else
        tx_shift <= {tx_shift[6:0], 1'b0};
    end
  end

  assign spi_miso = cs_active ? tx_shift[7] : 1'b0;

endmodule

`default_nettype wire

//--- src/cmd_parser.sv
`timescale 1ns/100ps
`default_nettype none

`include "esp_ctrl_cfg.svh"

module cmd_parser (
  input  logic               clk,
  input  logic               cass_out_sel_n,
  input  logic [7:0]         rx_byte,
  input  logic               rx_valid,
  output esp_ctrl_pkg::cmd_e cmd,
  output logic [7:0]         param0,
  output logic [7:0]         param1,
  output logic               exec,
  output logic               cmd_error
);

  import esp_ctrl_pkg::*;

  localparam int NPARAM = `ESP_CTRL_MAX_PARAMS;
  localparam int CNT_W  = $clog2(NPARAM + 1);
  localparam int IDX_W  = $clog2(NPARAM);

  parser_state_e    state;
  cmd_e             op_in;
  cmd_e             pend_op;
  logic             op_known;
  logic [CNT_W-1:0] op_params;
  logic [CNT_W-1:0] bytes_left;
  logic [IDX_W-1:0] idx;
  logic             last_param;

  logic [7:0] param_buf [0:NPARAM-1];
  logic [7:0] param_q   [0:NPARAM-1];

  assign op_in = cmd_e'(rx_byte);

  // parameter count per opcode
  always_comb begin
    op_known  = 1'b1;
    op_params = '0;
    case (op_in)
      get_cookie, get_version, ptrs_rst,
      z80_pause, z80_resume, get_spi_data: op_params = CNT_W'(0);
      send_keyb:                           op_params = CNT_W'(2);
      set_led, set_spi_ctrl_reg,
      set_spi_data, set_esp_status:        op_params = CNT_W'(1);
      default:                             op_known  = 1'b0;
    endcase
  end

  assign last_param = (state == read_bytes) && rx_valid && (bytes_left == CNT_W'(1));

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      state      <= idle;
      cmd        <= get_cookie;
      pend_op    <= get_cookie;
      bytes_left <= '0;
      idx        <= '0;
      exec       <= 1'b0;
      cmd_error  <= 1'b0;
    end else begin
      exec <= 1'b0;
      case (state)
        idle: begin
          if (rx_valid) begin
            if (!op_known) begin
              // sticky until reset
              cmd_error <= 1'b1;
            end else if (op_params == '0) begin
              cmd  <= op_in;
              exec <= 1'b1;
            end else begin
              pend_op    <= op_in;
              bytes_left <= op_params;
              idx        <= '0;
              state      <= read_bytes;
            end
          end
        end
        read_bytes: begin
          if (rx_valid) begin
            idx        <= idx + IDX_W'(1);
            bytes_left <= bytes_left - CNT_W'(1);
            if (last_param) begin
              cmd   <= pend_op;
              exec  <= 1'b1;
              state <= idle;
            end
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // params collect in a buffer and only reach the outputs with exec
  always_ff @(posedge clk) begin
    if (state == read_bytes && rx_valid)
      param_buf[idx] <= rx_byte;
    if (last_param) begin
      for (int i = 0; i < NPARAM; i++) begin
        param_q[i] <= (IDX_W'(i) == idx) ? rx_byte : param_buf[i];
      end
    end
  end

  assign param0 = param_q[0];
  assign param1 = param_q[1];

endmodule

`default_nettype wire

//--- src/cmd_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "esp_ctrl_cfg.svh"

module cmd_regs (
  input  logic               clk,
  input  logic               cass_out_sel_n,
  input  esp_ctrl_pkg::cmd_e cmd,
  input  logic [7:0]         param0,
  input  logic [7:0]         param1,
  input  logic               exec,
  input  logic [7:0]         flash_data,
  output logic [7:0]         tx_byte,
  output logic               led_red,
  output logic               led_green,
  output logic               led_blue,
  output logic [7:0]         esp_status,
  output logic               keyb_pressed,
  output logic               z80_rst,
  output logic               z80_paused
);

  import esp_ctrl_pkg::*;

  localparam int ROWS  = `ESP_CTRL_KEYB_ROWS;
  localparam int ROW_W = $clog2(ROWS);
  localparam int RST_W = $clog2(`ESP_CTRL_RST_CYCLES + 1);

  logic [7:0]       keyb_rows [0:ROWS-1];
  logic [RST_W-1:0] rst_cnt;

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      led_red    <= 1'b0;
      led_green  <= 1'b0;
      led_blue   <= 1'b0;
      esp_status <= 8'h00;
      z80_paused <= 1'b1;
      tx_byte    <= 8'h00;
      for (int r = 0; r < ROWS; r++) begin
        keyb_rows[r] <= 8'h00;
      end
    end else if (exec) begin
      case (cmd)
        set_led: begin
          led_red   <= param0[0];
          led_green <= param0[1];
          led_blue  <= param0[2];
        end
        set_esp_status: esp_status <= param0;
        send_keyb:      keyb_rows[param0[ROW_W-1:0]] <= param1;
        z80_pause:      z80_paused <= 1'b1;
        z80_resume:     z80_paused <= 1'b0;
        ptrs_rst:       z80_paused <= 1'b0;
        // answers go out during the following dummy byte
        get_cookie:     tx_byte <= `ESP_CTRL_COOKIE;
        get_version:    tx_byte <= {`ESP_CTRL_VERSION_MAJOR, `ESP_CTRL_VERSION_MINOR};
        get_spi_data:   tx_byte <= flash_data;
        default: ;
      endcase
    end
  end

  // z80 reset pulse, high while the counter runs down
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n)
      rst_cnt <= '0;
    else if (exec && cmd == ptrs_rst)
      rst_cnt <= RST_W'(`ESP_CTRL_RST_CYCLES);
    else if (rst_cnt != '0)
      rst_cnt <= rst_cnt - RST_W'(1);
  end

  assign z80_rst = (rst_cnt != '0);

  // any key down anywhere in the matrix
  always_comb begin
    keyb_pressed = 1'b0;
    for (int r = 0; r < ROWS; r++) begin
      keyb_pressed = keyb_pressed | (|keyb_rows[r]);
    end
  end

endmodule

`default_nettype wire

//--- src/flash_spi_master.sv
`timescale 1ns/100ps
`default_nettype none

`include "esp_ctrl_cfg.svh"

module flash_spi_master (
  input  logic               clk,
  input  logic               cass_out_sel_n,
  input  esp_ctrl_pkg::cmd_e cmd,
  input  logic [7:0]         param0,
  input  logic               exec,
  input  logic               flash_so,
  output logic               flash_cs_n,
  output logic               flash_clk,
  output logic               flash_si,
  output logic [7:0]         flash_data
);

  import esp_ctrl_pkg::*;

  // low bits time a half period, then a clock phase bit,
  // three bits of bit index and the busy bit on top
  localparam int HALF_W = $clog2(`ESP_CTRL_FLASH_HALF_BIT);
  localparam int CNT_W  = HALF_W + 5;

  logic [CNT_W-1:0] xfer_cnt;
  logic [7:0]       shift_reg;
  logic             ctrl_cs;
  logic             busy;
  logic             start;
  logic             phase_edge;
  logic             drive_edge;
  logic             capture_edge;

  assign busy         = xfer_cnt[CNT_W-1];
  assign start        = exec && (cmd == set_spi_data) && !busy;
  assign phase_edge   = busy && (xfer_cnt[HALF_W-1:0] == '0);
  assign drive_edge   = phase_edge && !xfer_cnt[HALF_W];
  assign capture_edge = phase_edge && xfer_cnt[HALF_W];

  // control register, only bit 7 (chip select) is used here
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n)
      ctrl_cs <= 1'b0;
    else if (exec && cmd == set_spi_ctrl_reg)
      ctrl_cs <= param0[7];
  end

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      xfer_cnt <= '0;
      flash_si <= 1'b0;
    end else if (busy) begin
      xfer_cnt <= xfer_cnt + CNT_W'(1);
      if (drive_edge)
        flash_si <= shift_reg[7];
    end else if (start) begin
      xfer_cnt <= {1'b1, {(CNT_W-1){1'b0}}};
    end
  end

  // same register shifts data out and the flash reply in
  always_ff @(posedge clk) begin
    if (capture_edge)
      shift_reg <= {shift_reg[6:0], flash_so};
    else if (start)
      shift_reg <= param0;
  end

  assign flash_data = shift_reg;
  assign flash_cs_n = ~ctrl_cs;
  assign flash_clk  = xfer_cnt[HALF_W];

endmodule

`default_nettype wire

//--- src/esp_ctrl_top.sv
`timescale 1ns/100ps
`default_nettype none

module esp_ctrl_top (
  input  logic       clk,
  input  logic       cass_out_sel_n,
  input  logic       spi_cs_n,
  input  logic       spi_sck,
  input  logic       spi_mosi,
  input  logic       flash_so,
  output logic       spi_miso,
  output logic       flash_cs_n,
  output logic       flash_clk,
  output logic       flash_si,
  output logic       led_red,
  output logic       led_green,
  output logic       led_blue,
  output logic [7:0] esp_status,
  output logic       keyb_pressed,
  output logic       z80_rst,
  output logic       z80_paused,
  output logic       cmd_error
);

  import esp_ctrl_pkg::*;

  logic [7:0] rx_byte;
  logic       rx_valid;
  logic [7:0] tx_byte;
  cmd_e       cmd;
  logic [7:0] param0;
  logic [7:0] param1;
  logic       exec;
  logic [7:0] flash_data;

  esp_spi_slave i_esp_spi_slave (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .spi_cs_n       (spi_cs_n),
    .spi_sck        (spi_sck),
    .spi_mosi       (spi_mosi),
    .tx_byte        (tx_byte),
    .spi_miso       (spi_miso),
    .rx_byte        (rx_byte),
    .rx_valid       (rx_valid)
  );

  cmd_parser i_cmd_parser (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .rx_byte        (rx_byte),
    .rx_valid       (rx_valid),
    .cmd            (cmd),
    .param0         (param0),
    .param1         (param1),
    .exec           (exec),
    .cmd_error      (cmd_error)
  );

  cmd_regs i_cmd_regs (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .cmd            (cmd),
    .param0         (param0),
    .param1         (param1),
    .exec           (exec),
    .flash_data     (flash_data),
    .tx_byte        (tx_byte),
    .led_red        (led_red),
    .led_green      (led_green),
    .led_blue       (led_blue),
    .esp_status     (esp_status),
    .keyb_pressed   (keyb_pressed),
    .z80_rst        (z80_rst),
    .z80_paused     (z80_paused)
  );

  flash_spi_master i_flash_spi_master (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .cmd            (cmd),
    .param0         (param0),
    .exec           (exec),
    .flash_so       (flash_so),
    .flash_cs_n     (flash_cs_n),
    .flash_clk      (flash_clk),
    .flash_si       (flash_si),
    .flash_data     (flash_data)
  );

endmodule

`default_nettype wire

//--- verif/esp_ctrl_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "esp_ctrl_cfg.svh"

module esp_ctrl_tb;

  import esp_ctrl_pkg::*;

  localparam int NUM_RANDOM     = 200;
  localparam int TIMEOUT_CYCLES = NUM_RANDOM * 2000 + 50000;

  // major 0 in bits 7:5 above minor 3
  localparam logic [7:0] VERSION_BYTE = 8'h03;

  logic       clk = 1'b0;
  logic       cass_out_sel_n;
  logic       spi_cs_n;
  logic       spi_sck;
  logic       spi_mosi;
  logic       flash_so;
  logic       spi_miso;
  logic       flash_cs_n;
  logic       flash_clk;
  logic       flash_si;
  logic       led_red;
  logic       led_green;
  logic       led_blue;
  logic [7:0] esp_status;
  logic       keyb_pressed;
  logic       z80_rst;
  logic       z80_paused;
  logic       cmd_error;

  // reference model
  logic [2:0] m_led;
  logic [7:0] m_status;
  logic [7:0] m_rows [0:7];
  logic       m_paused;
  logic       m_error;
  logic       m_cs_n;
  logic [7:0] m_flash;

  logic [15:0] lfsr = 16'd59780;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  int          rst_high = 0;
  int          rst_last_len = 0;
  int          rst_pulses = 0;

  esp_ctrl_top i_esp_ctrl_top (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .spi_cs_n       (spi_cs_n),
    .spi_sck        (spi_sck),
    .spi_mosi       (spi_mosi),
    .flash_so       (flash_so),
    .spi_miso       (spi_miso),
    .flash_cs_n     (flash_cs_n),
    .flash_clk      (flash_clk),
    .flash_si       (flash_si),
    .led_red        (led_red),
    .led_green      (led_green),
    .led_blue       (led_blue),
    .esp_status     (esp_status),
    .keyb_pressed   (keyb_pressed),
    .z80_rst        (z80_rst),
    .z80_paused     (z80_paused),
    .cmd_error      (cmd_error)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d clocks, errors so far: %0d", cycles, errors);
      $display("Simulation failed");
      $finish;
    end
  end

  // measures each z80 reset pulse in clocks
  always @(posedge clk) begin
    if (z80_rst) begin
      rst_high <= rst_high + 1;
    end else if (rst_high != 0) begin
      rst_last_len <= rst_high;
      rst_pulses   <= rst_pulses + 1;
      rst_high     <= 0;
    end
  end

  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_bits(input int n, output logic [7:0] v);
    v = 8'h00;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[6:0], lfsr[0]};
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_cmd(input cmd_e op, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: spi_miso reply to %s got %h expected %h",
               $time, op.name(), got, exp);
    end
  endtask

  task automatic compare_outputs();
    logic pressed;
    pressed = 1'b0;
    for (int r = 0; r < 8; r++) begin
      pressed = pressed | (|m_rows[r]);
    end
    check_bit("led_red", led_red, m_led[0]);
    check_bit("led_green", led_green, m_led[1]);
    check_bit("led_blue", led_blue, m_led[2]);
    check_byte("esp_status", esp_status, m_status);
    check_bit("keyb_pressed", keyb_pressed, pressed);
    check_bit("z80_paused", z80_paused, m_paused);
    check_bit("cmd_error", cmd_error, m_error);
    check_bit("flash_cs_n", flash_cs_n, m_cs_n);
    check_bit("z80_rst", z80_rst, 1'b0);
  endtask

  // spi mode 0 with 8 clocks per half period
  task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
    rx = 8'h00;
    for (int b = 7; b >= 0; b--) begin
      spi_mosi <= tx[b];
      repeat (8) @(posedge clk);
      spi_sck <= 1'b1;
      // rising edges 2 to 8 carry reply bits 7 to 1
      if (b < 7)
        rx[b + 1] = spi_miso;
      repeat (8) @(posedge clk);
      spi_sck <= 1'b0;
    end
  endtask

  task automatic send_cmd(input int n, input logic [7:0] b0, input logic [7:0] b1,
                          input logic [7:0] b2, output logic [7:0] last_rx);
    logic [7:0] frame [0:2];
    frame[0] = b0;
    frame[1] = b1;
    frame[2] = b2;
    @(posedge clk);
    spi_cs_n <= 1'b0;
    repeat (8) @(posedge clk);
    for (int i = 0; i < n; i++) begin
      spi_byte(frame[i], last_rx);
    end
    repeat (8) @(posedge clk);
    spi_cs_n <= 1'b1;
    repeat (6) @(posedge clk);
  endtask

  // flash side sets the reply bit in the low phase and takes flash_si at rising flash_clk
  task automatic flash_model(input logic [7:0] reply, output logic [7:0] si_seen);
    si_seen = 8'h00;
    for (int b = 7; b >= 0; b--) begin
      @(posedge clk);
      while (flash_clk)
        @(posedge clk);
      flash_so <= reply[b];
      @(posedge clk);
      while (!flash_clk)
        @(posedge clk);
      si_seen[b] = flash_si;
    end
  endtask

  task automatic flash_exchange(input logic [7:0] data, input logic [7:0] reply);
    logic [7:0] si_seen;
    logic [7:0] rx;
    fork
      send_cmd(2, set_spi_data, data, 8'h00, rx);
      flash_model(reply, si_seen);
    join
    check_byte("flash_si", si_seen, data);
    m_flash = reply;
    send_cmd(2, get_spi_data, 8'h00, 8'h00, rx);
    check_cmd(get_spi_data, rx & 8'hFE, m_flash & 8'hFE);
  endtask

  initial begin : main
    logic [7:0] sel;
    logic [7:0] p0;
    logic [7:0] p1;
    logic [7:0] rx;
    int         pulses;
    cass_out_sel_n <= 1'b0;
    spi_cs_n       <= 1'b1;
    spi_sck        <= 1'b0;
    spi_mosi       <= 1'b0;
    flash_so       <= 1'b0;
    m_led          = 3'b000;
    m_status       = 8'h00;
    m_paused       = 1'b1;
    m_error        = 1'b0;
    m_cs_n         = 1'b1;
    m_flash        = 8'h00;
    for (int r = 0; r < 8; r++) begin
      m_rows[r] = 8'h00;
    end

    repeat (16) @(posedge clk);
    cass_out_sel_n <= 1'b1;
    repeat (4) @(posedge clk);
    compare_outputs();
    check_bit("flash_clk", flash_clk, 1'b0);

    send_cmd(2, get_cookie, 8'h00, 8'h00, rx);
    check_cmd(get_cookie, rx & 8'hFE, `ESP_CTRL_COOKIE & 8'hFE);
    send_cmd(2, get_version, 8'h00, 8'h00, rx);
    check_cmd(get_version, rx & 8'hFE, VERSION_BYTE & 8'hFE);

    // z80 reset pulse followed by pause and resume
    pulses = rst_pulses;
    send_cmd(1, ptrs_rst, 8'h00, 8'h00, rx);
    m_paused = 1'b0;
    while (rst_pulses == pulses)
      @(posedge clk);
    check_byte("z80_rst pulse length", 8'(rst_last_len), 8'(`ESP_CTRL_RST_CYCLES));
    compare_outputs();
    send_cmd(1, z80_pause, 8'h00, 8'h00, rx);
    m_paused = 1'b1;
    compare_outputs();
    send_cmd(1, z80_resume, 8'h00, 8'h00, rx);
    m_paused = 1'b0;
    compare_outputs();

    send_cmd(2, set_spi_ctrl_reg, 8'h80, 8'h00, rx);
    m_cs_n = 1'b0;
    compare_outputs();
    flash_exchange(8'hA5, 8'h3C);
    send_cmd(2, set_spi_ctrl_reg, 8'h00, 8'h00, rx);
    m_cs_n = 1'b1;
    compare_outputs();

    for (int n = 0; n < NUM_RANDOM; n++) begin
      rand_bits(4, sel);
      rand_bits(8, p0);
      rand_bits(8, p1);
      case (sel[3:0])
        4'd0, 4'd1, 4'd2: begin
          send_cmd(2, set_led, p0, 8'h00, rx);
          m_led = p0[2:0];
        end
        4'd3, 4'd4, 4'd5: begin
          send_cmd(2, set_esp_status, p0, 8'h00, rx);
          m_status = p0;
        end
        4'd6, 4'd7, 4'd8: begin
          // half of the writes release the row
          if (!p0[7])
            p1 = 8'h00;
          send_cmd(3, send_keyb, p0, p1, rx);
          m_rows[p0[2:0]] = p1;
        end
        4'd9: begin
          send_cmd(1, z80_pause, 8'h00, 8'h00, rx);
          m_paused = 1'b1;
        end
        4'd10: begin
          send_cmd(1, z80_resume, 8'h00, 8'h00, rx);
          m_paused = 1'b0;
        end
        4'd11: begin
          send_cmd(2, set_spi_ctrl_reg, p0, 8'h00, rx);
          m_cs_n = ~p0[7];
        end
        4'd12: flash_exchange(p0, p1);
        4'd13: begin
          send_cmd(2, get_cookie, 8'h00, 8'h00, rx);
          check_cmd(get_cookie, rx & 8'hFE, `ESP_CTRL_COOKIE & 8'hFE);
        end
        4'd14: begin
          send_cmd(2, get_version, 8'h00, 8'h00, rx);
          check_cmd(get_version, rx & 8'hFE, VERSION_BYTE & 8'hFE);
        end
        default: begin
          // 128 and up is never a valid opcode
          send_cmd(1, {1'b1, p0[6:0]}, 8'h00, 8'h00, rx);
          m_error = 1'b1;
        end
      endcase
      compare_outputs();
    end

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- esp_ctrl_top.f
+incdir+include
src/esp_ctrl_pkg.sv
src/esp_spi_slave.sv
src/cmd_parser.sv
src/cmd_regs.sv
src/flash_spi_master.sv
src/esp_ctrl_top.sv
verif/esp_ctrl_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the esp_ctrl testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -f esp_ctrl_top.f --top-module esp_ctrl_tb \
  -Mdir "$OBJ" -o esp_ctrl_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$OBJ/esp_ctrl_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Simulation completed successfully" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
